/* source/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==============================
// Datapath widths
// ==============================

// Register and address width of the core
`define CPU_XLEN 32

// Tag that marks each issued instruction
`define CPU_TAG_BITS 4

// ==============================
// Machine CSR addresses
// ==============================

`define CPU_CSR_MSCRATCH 12'h340
`define CPU_CSR_MEPC 12'h341
`define CPU_CSR_MTVEC 12'h305

`endif

/* source/cpu_pkg.sv */
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_TAG_BITS-1:0] tag_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [11:0] csr_index_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_t;

	typedef enum logic [2:0] {SEL_ZERO, SEL_RS1, SEL_RS2, SEL_PC, SEL_IMM} operand_sel_t;

	// Code 7 is left unused and faults the stage
	typedef enum logic [2:0] {
		CLASS_ARITH, CLASS_COMPARE, CLASS_JUMP, CLASS_BRANCH,
		CLASS_LOAD, CLASS_STORE, CLASS_COMPLEX
	} exec_class_t;

	typedef enum logic [3:0] {
		OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_MRET
	} complex_op_t;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_width_t;

	typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_DONE} muldiv_state_t;

	// Decoded instruction as handed over by decode
	typedef struct packed {
		tag_t tag;
		word_t pc;
		word_t imm;
		reg_index_t rd;
		exec_class_t exec_class;
		alu_op_t alu_op;
		operand_sel_t operand_a;
		operand_sel_t operand_b;
		complex_op_t complex_op;
		mem_width_t mem_width;
		logic mem_signed;
	} decode_data_t;

	// Result handed to the memory stage
	typedef struct packed {
		tag_t tag;
		reg_index_t rd;
		word_t rd_value;
		word_t mem_address;
		logic mem_read;
		logic mem_write;
		mem_width_t mem_width;
		logic mem_signed;
	} execute_data_t;

endpackage

/* source/cpu_alu.sv */
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input alu_op_t i_op,
	input word_t i_a,
	input word_t i_b,
	output word_t o_result,
	output logic o_compare
);

	logic [4:0] shift;

	assign shift = i_b[4:0];

	// ==============================
	// Compare flag for branches and set ops
	// ==============================

	always_comb begin
		case (i_op)
			ALU_SLT: o_compare = $signed(i_a) < $signed(i_b);
			ALU_SLTU: o_compare = i_a < i_b;
			ALU_EQ: o_compare = i_a == i_b;
			ALU_NE: o_compare = i_a != i_b;
			ALU_GE: o_compare = $signed(i_a) >= $signed(i_b);
			ALU_GEU: o_compare = i_a >= i_b;
			default: o_compare = 1'b0;
		endcase
	end

	// ==============================
	// Arithmetic result
	// ==============================

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR: o_result = i_a | i_b;
			ALU_XOR: o_result = i_a ^ i_b;
			ALU_SLL: o_result = i_a << shift;
			ALU_SRL: o_result = i_a >> shift;
			ALU_SRA: o_result = $signed(i_a) >>> shift;
			// Compare ops give the flag zero extended
			default: o_result = {{31{1'b0}}, o_compare};
		endcase
	end

endmodule

/* source/cpu_muldiv.sv */
`timescale 1ns/1ps

module cpu_muldiv import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input complex_op_t i_op,
	input word_t i_a,
	input word_t i_b,
	output logic o_done,
	output word_t o_result
);

	muldiv_state_t state;
	logic [4:0] count;
	complex_op_t op;
	logic [63:0] acc;
	word_t operand;
	logic negate;
	logic div_zero;

	logic a_neg;
	logic b_neg;
	logic is_div;
	logic [32:0] mul_sum;
	logic [32:0] div_diff;
	logic [63:0] product;

	// Only MULH, DIV and REM take signed operands
	assign a_neg = (i_op inside {OP_MULH, OP_DIV, OP_REM}) && i_a[31];
	assign b_neg = (i_op inside {OP_MULH, OP_DIV, OP_REM}) && i_b[31];
	assign is_div = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

	// Multiply keeps {high, multiplier} in acc, divide keeps {remainder, dividend}
	assign mul_sum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, operand} : 33'd0);
	assign div_diff = acc[63:31] - {1'b0, operand};
	assign product = negate ? -acc : acc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= MD_IDLE;
			count <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				MD_IDLE: if (i_start) begin
					state <= MD_RUN;
					count <= '0;
				end
				MD_RUN: begin
					count <= count + 5'd1;
					if (count == 5'd31)
						state <= MD_DONE;
				end
				default: begin
					o_done <= 1'b1;
					state <= MD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == MD_IDLE && i_start) begin
			op <= i_op;
			acc <= {32'd0, a_neg ? -i_a : i_a};
			operand <= b_neg ? -i_b : i_b;
			negate <= (i_op == OP_REM) ? a_neg : (a_neg ^ b_neg);
			div_zero <= (i_b == '0);
		end else if (state == MD_RUN) begin
			if (!is_div)
				acc <= {mul_sum, acc[31:1]};
			else if (!div_diff[32])
				acc <= {div_diff[31:0], acc[30:0], 1'b1};
			else
				acc <= {acc[62:0], 1'b0};
		end else if (state == MD_DONE) begin
			case (op)
				OP_MUL: o_result <= product[31:0];
				OP_MULH, OP_MULHU: o_result <= product[63:32];
				// Divide by zero leaves all ones regardless of sign
				OP_DIV, OP_DIVU: o_result <= div_zero ? '1 : product[31:0];
				OP_REM, OP_REMU: o_result <= negate ? -acc[63:32] : acc[63:32];
				default: o_result <= '0;
			endcase
		end
	end

endmodule

/* source/cpu_csr_file.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_csr_file import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input csr_index_t i_index,
	input logic i_write,
	input word_t i_wdata,
	output word_t o_rdata,
	output word_t o_mepc
);

	word_t mscratch;
	word_t mepc;
	word_t mtvec;

	// Read port with zero for unknown addresses
	always_comb begin
		case (i_index)
			`CPU_CSR_MSCRATCH: o_rdata = mscratch;
			`CPU_CSR_MEPC: o_rdata = mepc;
			`CPU_CSR_MTVEC: o_rdata = mtvec;
			default: o_rdata = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mscratch <= '0;
			mepc <= '0;
			mtvec <= '0;
		end else if (i_write) begin
			case (i_index)
				`CPU_CSR_MSCRATCH: mscratch <= i_wdata;
				`CPU_CSR_MEPC: mepc <= i_wdata;
				`CPU_CSR_MTVEC: mtvec <= i_wdata;
				default: ;
			endcase
		end
	end

	assign o_mepc = mepc;

endmodule

/* source/cpu_execute.sv */
`timescale 1ns/1ps

module cpu_execute import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input decode_data_t i_data,
	input word_t i_rs1,
	input word_t i_rs2,
	input logic i_memory_busy,
	output logic o_busy,
	output execute_data_t o_data,
	output logic o_jump,
	output word_t o_jump_pc,
	output logic o_fault,
	output csr_index_t o_csr_index,
	input word_t i_csr_rdata,
	output logic o_csr_write,
	output word_t o_csr_wdata,
	input word_t i_epc
);

	execute_data_t data;
	word_t operand_a, operand_b, alu_result, pc_next, csr_update, muldiv_result;
	logic alu_compare, accept;
	logic muldiv_start, muldiv_done, muldiv_active, muldiv_ready;

	function automatic word_t select_operand(input operand_sel_t sel, input word_t rs1,
		input word_t rs2, input word_t pc, input word_t imm);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	// ==============================
	// Functional units
	// ==============================

	assign operand_a = select_operand(i_data.operand_a, i_rs1, i_rs2, i_data.pc, i_data.imm);
	assign operand_b = select_operand(i_data.operand_b, i_rs1, i_rs2, i_data.pc, i_data.imm);

	cpu_alu alu_inst (.i_op(i_data.alu_op), .i_a(operand_a), .i_b(operand_b),
		.o_result(alu_result), .o_compare(alu_compare));

	// Decode holds rs1/rs2 while busy, so the unit samples them a cycle late
	cpu_muldiv muldiv_inst (.i_clock(i_clock), .i_reset(i_reset), .i_start(muldiv_start),
		.i_op(i_data.complex_op), .i_a(i_rs1), .i_b(i_rs2),
		.o_done(muldiv_done), .o_result(muldiv_result));

	always_comb begin
		case (i_data.complex_op)
			OP_CSRRS: csr_update = i_csr_rdata | i_rs1;
			OP_CSRRC: csr_update = i_csr_rdata & ~i_rs1;
			default: csr_update = i_rs1;
		endcase
	end

	assign pc_next = i_data.pc + 32'd4;
	assign o_csr_index = i_data.imm[11:0];
	assign o_data = data;
	// Also stall while a CSR write lands, so the next read sees it
	assign o_busy = muldiv_active || o_csr_write || i_memory_busy;
	assign accept = (i_data.tag != data.tag) && !o_busy;

	// ==============================
	// Dispatch and output register
	// ==============================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			data <= '0;
			o_jump <= 1'b0;
			o_fault <= 1'b0;
			o_csr_write <= 1'b0;
			muldiv_start <= 1'b0;
			muldiv_active <= 1'b0;
			muldiv_ready <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			o_csr_write <= 1'b0;
			muldiv_start <= 1'b0;
			if (accept) begin
				data.rd <= i_data.rd;
				data.mem_address <= alu_result;
				data.mem_read <= (i_data.exec_class == CLASS_LOAD);
				data.mem_write <= (i_data.exec_class == CLASS_STORE);
				data.mem_width <= i_data.mem_width;
				data.mem_signed <= i_data.mem_signed;
				case (i_data.exec_class)
					CLASS_ARITH, CLASS_LOAD: data.rd_value <= alu_result;
					CLASS_COMPARE: data.rd_value <= {{31{1'b0}}, alu_compare};
					CLASS_JUMP: data.rd_value <= pc_next;
					CLASS_STORE: data.rd_value <= i_rs2;
					default: ;
				endcase
				case (i_data.exec_class)
					CLASS_ARITH, CLASS_COMPARE, CLASS_LOAD, CLASS_STORE: data.tag <= i_data.tag;
					CLASS_JUMP: begin
						o_jump <= 1'b1;
						o_jump_pc <= alu_result;
						data.tag <= i_data.tag;
					end
					CLASS_BRANCH: begin
						o_jump <= 1'b1;
						o_jump_pc <= alu_compare ? i_data.pc + i_data.imm : pc_next;
						data.tag <= i_data.tag;
					end
					CLASS_COMPLEX: case (i_data.complex_op)
						OP_CSRRW, OP_CSRRS, OP_CSRRC: begin
							data.rd_value <= i_csr_rdata;
							o_csr_write <= 1'b1;
							o_csr_wdata <= csr_update;
							data.tag <= i_data.tag;
						end
						OP_MRET: begin
							o_jump <= 1'b1;
							o_jump_pc <= i_epc;
							data.tag <= i_data.tag;
						end
						OP_MUL, OP_MULH, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
							muldiv_active <= 1'b1;
							muldiv_start <= 1'b1;
						end
						default: o_fault <= 1'b1;
					endcase
					default: o_fault <= 1'b1;
				endcase
			end else if (muldiv_active && (muldiv_done || muldiv_ready)) begin
				// Result stays in the unit until memory takes it
				if (i_memory_busy) begin
					muldiv_ready <= 1'b1;
				end else begin
					data.tag <= i_data.tag;
					data.rd_value <= muldiv_result;
					muldiv_active <= 1'b0;
					muldiv_ready <= 1'b0;
				end
			end
		end
	end

endmodule

/* source/cpu_execute_top.sv */
`timescale 1ns/1ps

module cpu_execute_top import cpu_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input decode_data_t i_data,
	input word_t i_rs1,
	input word_t i_rs2,
	input logic i_memory_busy,
	output logic o_busy,
	output execute_data_t o_data,
	output logic o_jump,
	output word_t o_jump_pc,
	output logic o_fault
);

	csr_index_t csr_index;
	word_t csr_rdata;
	word_t csr_wdata;
	word_t mepc;
	logic csr_write;

	cpu_execute execute_inst (.i_clock(i_clock), .i_reset(i_reset), .i_data(i_data),
		.i_rs1(i_rs1), .i_rs2(i_rs2), .i_memory_busy(i_memory_busy), .o_busy(o_busy),
		.o_data(o_data), .o_jump(o_jump), .o_jump_pc(o_jump_pc), .o_fault(o_fault),
		.o_csr_index(csr_index), .i_csr_rdata(csr_rdata), .o_csr_write(csr_write),
		.o_csr_wdata(csr_wdata), .i_epc(mepc));

	cpu_csr_file csr_file_inst (.i_clock(i_clock), .i_reset(i_reset), .i_index(csr_index),
		.i_write(csr_write), .i_wdata(csr_wdata), .o_rdata(csr_rdata), .o_mepc(mepc));

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic o_clock,
	output logic o_reset
);

	// 8 ns period
	initial begin
		o_clock = 1'b0;
		forever #4 o_clock = ~o_clock;
	end

	// Reset held over the first three rising edges
	initial begin
		o_reset = 1'b1;
		repeat (3) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

/* verification/tb_cpu_execute.sv */
`timescale 1ns/1ps

`include "cpu_consts.svh"

module tb_cpu_execute import cpu_pkg::*; ();

	logic clock, reset, memory_busy, busy, jump, fault;
	decode_data_t data_in;
	execute_data_t data_out;
	word_t rs1, rs2, jump_pc, rng;
	tag_t next_tag;
	int error_count, timeout_count;

	tb_clock_gen clock_gen_inst (.o_clock(clock), .o_reset(reset));

	cpu_execute_top cpu_execute_top_inst (.i_clock(clock), .i_reset(reset), .i_data(data_in),
		.i_rs1(rs1), .i_rs2(rs2), .i_memory_busy(memory_busy), .o_busy(busy),
		.o_data(data_out), .o_jump(jump), .o_jump_pc(jump_pc), .o_fault(fault));

	// ==============================
	// Stimulus and reference model
	// ==============================

	function automatic word_t xorshift();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// RISC-V meaning of each ALU op with compares giving 0 or 1
	function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
		logic signed [31:0] sa, sb;
		sa = a;
		sb = b;
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR: return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLL: return a << b[4:0];
			ALU_SRL: return a >> b[4:0];
			ALU_SRA: return sa >>> b[4:0];
			ALU_SLT: return word_t'(sa < sb);
			ALU_SLTU: return word_t'(a < b);
			ALU_EQ: return word_t'(a == b);
			ALU_NE: return word_t'(a != b);
			ALU_GE: return word_t'(sa >= sb);
			default: return word_t'(a >= b);
		endcase
	endfunction

	// 64-bit signed division covers the most-negative by minus one case
	function automatic word_t muldiv_model(input complex_op_t op, input word_t a, input word_t b);
		logic signed [63:0] sa, sb, sp, quot, rem;
		logic [63:0] up;
		sa = {{32{a[31]}}, a};
		sb = {{32{b[31]}}, b};
		sp = sa * sb;
		up = {32'd0, a} * {32'd0, b};
		quot = (b == '0) ? -64'sd1 : sa / sb;
		rem = (b == '0) ? sa : sa % sb;
		case (op)
			OP_MUL: return up[31:0];
			OP_MULH: return sp[63:32];
			OP_MULHU: return up[63:32];
			OP_DIV: return quot[31:0];
			OP_DIVU: return (b == '0) ? '1 : a / b;
			OP_REM: return rem[31:0];
			default: return (b == '0) ? a : a % b;
		endcase
	endfunction

	function automatic decode_data_t decode(input exec_class_t cls, input alu_op_t op,
		input operand_sel_t sel_a, input operand_sel_t sel_b, input word_t pc, input word_t imm);
		decode_data_t d;
		d = '0;
		d.exec_class = cls;
		d.alu_op = op;
		d.operand_a = sel_a;
		d.operand_b = sel_b;
		d.pc = pc;
		d.imm = imm;
		d.rd = reg_index_t'(xorshift());
		return d;
	endfunction

	task automatic check_word(input string what, input word_t got, input word_t expected);
		assert (got === expected) else begin
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic issue(input decode_data_t d, input word_t a, input word_t b);
		next_tag = next_tag + 4'd1;
		d.tag = next_tag;
		@(posedge clock);
		data_in <= d;
		rs1 <= a;
		rs2 <= b;
	endtask

	// Completion is the output tag taking the issued value
	task automatic wait_for_tag(input tag_t tag, input bit busy_until_done);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			#1;
			cycles++;
			if (busy_until_done && data_out.tag != tag)
				assert (busy) else begin
					$display("** Error at %0t: o_busy low before completion", $time);
					error_count++;
				end
		end while (data_out.tag != tag && cycles < 50);
		if (data_out.tag != tag) begin
			$display("Timeout: instruction with tag %0d did not complete in 50 cycles", tag);
			timeout_count++;
		end
	endtask

	task automatic run_instruction(input decode_data_t d, input word_t a, input word_t b,
		input bit busy_until_done);
		issue(d, a, b);
		wait_for_tag(next_tag, busy_until_done);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic test_alu();
		word_t a, b;
		alu_op_t op;
		for (int pair = 0; pair < 20; pair++) begin
			a = xorshift();
			// First pairs are equal to reach EQ and GE
			b = (pair < 4) ? a : xorshift();
			for (int k = 0; k <= 13; k++) begin
				op = alu_op_t'(k);
				run_instruction(decode(k < 8 ? CLASS_ARITH : CLASS_COMPARE, op, SEL_RS1,
					SEL_RS2, '0, '0), a, b, 1'b0);
				check_word($sformatf("%s result", op.name()), data_out.rd_value,
					alu_model(op, a, b));
				check_word("o_jump after ALU op", {31'd0, jump}, 32'd0);
			end
		end
	endtask

	task automatic test_jump_branch();
		word_t pc, imm, a, b, target;
		alu_op_t op;
		pc = xorshift() & ~32'd3;
		imm = 32'h0000_0120;
		run_instruction(decode(CLASS_JUMP, ALU_ADD, SEL_PC, SEL_IMM, pc, imm), '0, '0, 1'b0);
		check_word("JAL link value", data_out.rd_value, pc + 32'd4);
		check_word("JAL strobe", {31'd0, jump}, 32'd1);
		check_word("JAL target", jump_pc, pc + imm);
		a = xorshift();
		run_instruction(decode(CLASS_JUMP, ALU_ADD, SEL_RS1, SEL_IMM, pc, imm), a, '0, 1'b0);
		check_word("JALR target", jump_pc, a + imm);
		// Backward offset with compare ops standing for the branch conditions
		imm = 32'hffff_ffc0;
		for (int k = 8; k <= 13; k++) begin
			op = alu_op_t'(k);
			for (int same = 0; same < 2; same++) begin
				a = xorshift();
				b = same ? a : xorshift();
				target = (alu_model(op, a, b) != '0) ? pc + imm : pc + 32'd4;
				run_instruction(decode(CLASS_BRANCH, op, SEL_RS1, SEL_RS2, pc, imm), a, b, 1'b0);
				check_word("branch strobe", {31'd0, jump}, 32'd1);
				check_word($sformatf("branch %s target", op.name()), jump_pc, target);
			end
		end
	endtask

	task automatic test_load_store();
		decode_data_t d;
		word_t base, offset, value;
		for (int w = 0; w < 3; w++) begin
			base = xorshift();
			value = xorshift();
			offset = {{20{value[11]}}, value[11:0]};
			d = decode(CLASS_LOAD, ALU_ADD, SEL_RS1, SEL_IMM, '0, offset);
			d.mem_width = mem_width_t'(w);
			d.mem_signed = w[0];
			run_instruction(d, base, '0, 1'b0);
			check_word("load address", data_out.mem_address, base + offset);
			check_word("load rd index", {27'd0, data_out.rd}, {27'd0, d.rd});
			check_word("load controls", {27'd0, data_out.mem_read, data_out.mem_write,
				data_out.mem_width, data_out.mem_signed}, {27'd0, 2'b10, d.mem_width, d.mem_signed});
			d.exec_class = CLASS_STORE;
			run_instruction(d, base, value, 1'b0);
			check_word("store address", data_out.mem_address, base + offset);
			check_word("store data", data_out.rd_value, value);
			check_word("store controls", {27'd0, data_out.mem_read, data_out.mem_write,
				data_out.mem_width, data_out.mem_signed}, {27'd0, 2'b01, d.mem_width, d.mem_signed});
		end
	endtask

	task automatic test_muldiv();
		decode_data_t d;
		word_t a, b;
		complex_op_t op;
		for (int k = 0; k <= 6; k++) begin
			op = complex_op_t'(k);
			// Last two cases are divide by zero and signed overflow
			for (int n = 0; n < 5; n++) begin
				a = (n == 4) ? 32'h8000_0000 : xorshift();
				b = (n == 3) ? '0 : (n == 4) ? 32'hffff_ffff : xorshift();
				d = decode(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, '0, '0);
				d.complex_op = op;
				run_instruction(d, a, b, 1'b1);
				check_word($sformatf("%s of %h and %h", op.name(), a, b), data_out.rd_value,
					muldiv_model(op, a, b));
			end
		end
	endtask

	task automatic test_csr();
		decode_data_t d;
		word_t model_csr, value, target;
		model_csr = '0;
		d = decode(CLASS_COMPLEX, ALU_ADD, SEL_RS1, SEL_RS2, '0, {20'd0, `CPU_CSR_MSCRATCH});
		for (int k = 7; k <= 9; k++) begin
			d.complex_op = complex_op_t'(k);
			value = xorshift();
			run_instruction(d, value, '0, 1'b0);
			check_word($sformatf("%s old value", d.complex_op.name()), data_out.rd_value,
				model_csr);
			case (d.complex_op)
				OP_CSRRW: model_csr = value;
				OP_CSRRS: model_csr = model_csr | value;
				default: model_csr = model_csr & ~value;
			endcase
		end
		d.complex_op = OP_CSRRS;
		run_instruction(d, '0, '0, 1'b0);
		check_word("mscratch read back", data_out.rd_value, model_csr);
		target = xorshift() & ~32'd3;
		d.imm = {20'd0, `CPU_CSR_MEPC};
		d.complex_op = OP_CSRRW;
		run_instruction(d, target, '0, 1'b0);
		d.complex_op = OP_MRET;
		run_instruction(d, '0, '0, 1'b0);
		check_word("MRET strobe", {31'd0, jump}, 32'd1);
		check_word("MRET target", jump_pc, target);
	endtask

	task automatic test_backpressure();
		execute_data_t held;
		word_t a, b;
		a = xorshift();
		b = xorshift();
		held = data_out;
		@(posedge clock);
		memory_busy <= 1'b1;
		issue(decode(CLASS_ARITH, ALU_XOR, SEL_RS1, SEL_RS2, '0, '0), a, b);
		for (int cycle = 0; cycle < 10; cycle++) begin
			@(posedge clock);
			#1;
			assert (data_out == held) else begin
				$display("** Error at %0t: o_data changed while memory busy", $time);
				error_count++;
			end
		end
		@(posedge clock);
		memory_busy <= 1'b0;
		wait_for_tag(next_tag, 1'b0);
		check_word("result after release", data_out.rd_value, a ^ b);
	endtask

	initial begin
		int cycles;
		rng = 32'h9869;
		next_tag = '0;
		error_count = 0;
		timeout_count = 0;
		data_in = '0;
		rs1 = '0;
		rs2 = '0;
		memory_busy = 1'b0;
		cycles = 0;
		while (reset !== 1'b0 && cycles < 20) begin
			@(posedge clock);
			cycles++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			timeout_count++;
		end
		test_alu();
		test_jump_branch();
		test_load_store();
		test_muldiv();
		test_csr();
		test_backpressure();
		check_word("fault flag", {31'd0, fault}, 32'd0);
		$display("Summary: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* sim.f */
+incdir+source
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_muldiv.sv
source/cpu_csr_file.sv
source/cpu_execute.sv
source/cpu_execute_top.sv
verification/tb_clock_gen.sv
verification/tb_cpu_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
verilator --binary --timing --assert -f sim.f --top-module tb_cpu_execute -o tb_cpu_execute \
	&& ./obj_dir/tb_cpu_execute > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Result: build or run error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log \
	&& { echo "Result: FAIL"; exit 1; } \
	|| { echo "Result: PASS"; exit 0; }
